//--- vlog.f
+incdir+hdl
hdl/huff_pkg.sv
hdl/entry_sorter.sv
hdl/merge_step.sv
hdl/node_table.sv
hdl/build_control.sv
hdl/huffman_tree_builder.sv
sim/huffman_tree_builder_props.sv
sim/huffman_tree_builder_tb.sv

//--- sim/huffman_tree_builder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "huff_config.svh"

module huffman_tree_builder_tb;

	logic                    CLK;
	logic                    nRST;
	logic                    start;
	huff_pkg::weight_array_t weights;
	huff_pkg::node_table_t   nodes;
	logic                    done;

	integer seed;
	int     tests_run;
	int     tests_failed;
	int     total_errors;
	int     assert_fails;

	huffman_tree_builder UUT (
		.CLK     (CLK),
		.nRST    (nRST),
		.start   (start),
		.weights (weights),
		.nodes   (nodes),
		.done    (done)
	);

	always #20 CLK = ~CLK;

	////////////////////
	// Reference tree
	////////////////////

	// Two lightest active nodes merge, scan in ID order keeps lower ID on a tie
	function automatic huff_pkg::node_table_t model_tree(input huff_pkg::weight_array_t w);
		huff_pkg::node_table_t  t;
		logic [`HUFF_NODES-1:0] active;
		int                     a;
		int                     b;
		t = '0;
		active = '0;
		for (int i = 0; i < `HUFF_LEAVES; i++) begin
			t[i].left   = `HUFF_NO_NODE;
			t[i].right  = `HUFF_NO_NODE;
			t[i].weight = w[i];
			t[i].id     = `HUFF_ID_W'(i);
			active[i]   = 1'b1;
		end
		for (int n = `HUFF_LEAVES; n < `HUFF_NODES; n++) begin
			a = -1;
			b = -1;
			for (int i = 0; i < n; i++) begin
				if (active[i]) begin
					if (a < 0 || t[i].weight < t[a].weight) begin
						b = a;
						a = i;
					end else if (b < 0 || t[i].weight < t[b].weight) begin
						b = i;
					end
				end
			end
			t[n].left         = `HUFF_ID_W'(a);
			t[n].right        = `HUFF_ID_W'(b);
			t[n].weight       = `HUFF_WEIGHT_W'((int'(t[a].weight) + int'(t[b].weight)) % 256);
			t[n].id           = `HUFF_ID_W'(n);
			t[a].has_parent   = 1'b1;
			t[a].parent       = `HUFF_ID_W'(n);
			t[b].has_parent   = 1'b1;
			t[b].parent       = `HUFF_ID_W'(n);
			active[a]         = 1'b0;
			active[b]         = 1'b0;
			active[n]         = 1'b1;
		end
		return t;
	endfunction

	////////////////////
	// Helpers
	////////////////////

	task automatic pulse_start(input huff_pkg::weight_array_t w);
		@(posedge CLK);
		start   <= 1'b1;
		weights <= w;
		@(posedge CLK);
		start   <= 1'b0;
	endtask

	task automatic wait_for_done(input string name, inout int errs);
		int cycles;
		cycles = 0;
		do begin
			@(negedge CLK);
			cycles++;
		end while (!done && cycles < 1000);
		if (!done) begin
			$display("Timeout in %s: done did not rise within 1000 cycles", name);
			errs++;
		end
	endtask

	task automatic compare_table(input string name, input huff_pkg::node_table_t exp,
		inout int errs);
		for (int i = 0; i < `HUFF_NODES; i++) begin
			if (nodes[i] !== exp[i]) begin
				$display("ERROR at %0t ns: %s node %0d is %h, expected %h",
					$time, name, i, nodes[i], exp[i]);
				errs++;
			end
		end
	endtask

	task automatic build_and_check(input string name, input huff_pkg::weight_array_t w,
		inout int errs);
		pulse_start(w);
		wait_for_done(name, errs);
		compare_table(name, model_tree(w), errs);
	endtask

	task automatic report(input string name, input int errs);
		tests_run++;
		total_errors += errs;
		if (errs != 0) begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, errs);
		end else begin
			$display("Test %s ok", name);
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic check_reset_state();
		int errs;
		errs = 0;
		@(negedge CLK);
		if (done !== 1'b0) begin
			$display("ERROR at %0t ns: done is %b after reset, expected 0", $time, done);
			errs++;
		end
		for (int i = 0; i < `HUFF_NODES; i++) begin
			if (nodes[i].has_parent !== 1'b0 || nodes[i].weight !== '0) begin
				$display("ERROR at %0t ns: node %0d not cleared after reset", $time, i);
				errs++;
			end
		end
		report("reset_state", errs);
	endtask

	task automatic check_distinct_weights();
		huff_pkg::weight_array_t w;
		int                      errs;
		int                      sum;
		errs = 0;
		sum = 0;
		w = {8'd30, 8'd21, 8'd7, 8'd3, 8'd45, 8'd16, 8'd13, 8'd12, 8'd9, 8'd5};
		for (int i = 0; i < `HUFF_LEAVES; i++)
			sum += w[i];
		build_and_check("distinct_weights", w, errs);
		for (int i = 0; i < `HUFF_NODES - 1; i++) begin
			if (nodes[i].has_parent !== 1'b1) begin
				$display("ERROR at %0t ns: node %0d has no parent", $time, i);
				errs++;
			end
		end
		if (nodes[`HUFF_NODES-1].weight !== `HUFF_WEIGHT_W'(sum)) begin
			$display("ERROR at %0t ns: root weight %0d, expected %0d",
				$time, nodes[`HUFF_NODES-1].weight, sum);
			errs++;
		end
		report("distinct_weights", errs);
	endtask

	task automatic check_equal_weights();
		huff_pkg::weight_array_t w;
		int                      errs;
		errs = 0;
		for (int i = 0; i < `HUFF_LEAVES; i++)
			w[i] = 8'd7;
		build_and_check("equal_weights", w, errs);
		// All tied, so leaves 0 and 1 merge first
		if (nodes[`HUFF_LEAVES].left !== 5'd0 || nodes[`HUFF_LEAVES].right !== 5'd1) begin
			$display("ERROR at %0t ns: first merge took nodes %0d and %0d, expected 0 and 1",
				$time, nodes[`HUFF_LEAVES].left, nodes[`HUFF_LEAVES].right);
			errs++;
		end
		report("equal_weights", errs);
	endtask

	task automatic check_random_builds();
		huff_pkg::weight_array_t w;
		int                      errs;
		for (int n = 0; n < 20; n++) begin
			errs = 0;
			for (int i = 0; i < `HUFF_LEAVES; i++)
				w[i] = 8'(($unsigned($random(seed)) % 25) + 1);
			build_and_check($sformatf("random_%0d", n), w, errs);
			report($sformatf("random_%0d", n), errs);
		end
	endtask

	task automatic check_restart();
		huff_pkg::weight_array_t w1;
		huff_pkg::weight_array_t w2;
		int                      errs;
		errs = 0;
		w1 = {8'd4, 8'd19, 8'd2, 8'd11, 8'd8, 8'd25, 8'd1, 8'd14, 8'd6, 8'd10};
		w2 = {8'd12, 8'd3, 8'd17, 8'd9, 8'd22, 8'd5, 8'd15, 8'd2, 8'd20, 8'd8};
		build_and_check("restart_first", w1, errs);
		pulse_start(w2);
		@(negedge CLK);
		if (done !== 1'b0) begin
			$display("ERROR at %0t ns: done still high after a new start", $time);
			errs++;
		end
		// Second start lands in the middle of the sort
		repeat (4) @(posedge CLK);
		pulse_start(w1);
		wait_for_done("restart_second", errs);
		compare_table("restart_second", model_tree(w2), errs);
		report("restart", errs);
	endtask

	task automatic check_wrapping_sums();
		huff_pkg::weight_array_t w;
		int                      errs;
		errs = 0;
		w = {8'd140, 8'd100, 8'd230, 8'd60, 8'd90, 8'd250, 8'd120, 8'd150, 8'd180, 8'd200};
		build_and_check("wrapping_sums", w, errs);
		report("wrapping_sums", errs);
	endtask

	initial begin
		CLK          = 1'b0;
		nRST         = 1'b0;
		start        = 1'b0;
		weights      = '0;
		seed         = 14;
		tests_run    = 0;
		tests_failed = 0;
		total_errors = 0;
		repeat (10) @(posedge CLK);
		nRST <= 1'b1;

		check_reset_state();
		check_distinct_weights();
		check_equal_weights();
		check_random_builds();
		check_restart();
		check_wrapping_sums();

		assert_fails = UUT.u_props.fail_count;
		$display("Tests run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
			tests_run, tests_failed, total_errors, assert_fails);
		if (tests_failed == 0 && assert_fails == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/huffman_tree_builder_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "huff_config.svh"

module huffman_tree_builder_props (
	input wire logic                  CLK,
	input wire logic                  nRST,
	input wire logic                  start,
	input wire logic                  done,
	input wire logic                  sort_done,
	input wire huff_pkg::entry_list_t sorted_list,
	input wire huff_pkg::node_table_t nodes
);

	logic seen_start;

	// Failed assertion count
	int fail_count = 0;

	// Valid slots first, weights never falling
	function automatic logic list_ordered(input huff_pkg::entry_list_t l);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < `HUFF_LEAVES - 1; i++) begin
			if (!l[i].valid && l[i+1].valid)
				ok = 1'b0;
			if (l[i].valid && l[i+1].valid && l[i+1].weight < l[i].weight)
				ok = 1'b0;
		end
		return ok;
	endfunction

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST)
			seen_start <= 1'b0;
		else if (start)
			seen_start <= 1'b1;
	end

	////////////////////
	// Controller
	////////////////////

	done_needs_start: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(done) |-> seen_start)
		else begin
			$error("done rose with no start seen before it");
			fail_count++;
		end

	root_free_at_done: assert property (@(posedge CLK) disable iff (!nRST)
		done |-> !nodes[`HUFF_NODES-1].has_parent)
		else begin
			$error("root node has a parent while done is high");
			fail_count++;
		end

	////////////////////
	// Sorter
	////////////////////

	sort_done_single: assert property (@(posedge CLK) disable iff (!nRST)
		sort_done |=> !sort_done)
		else begin
			$error("sort_done held for more than one cycle");
			fail_count++;
		end

	sorted_at_done: assert property (@(posedge CLK) disable iff (!nRST)
		sort_done |-> list_ordered(sorted_list))
		else begin
			$error("list out of order at sort_done");
			fail_count++;
		end

endmodule

// Top level sees the controller and sorter wires together
bind huffman_tree_builder huffman_tree_builder_props u_props (
	.CLK         (CLK),
	.nRST        (nRST),
	.start       (start),
	.done        (done),
	.sort_done   (sort_done),
	.sorted_list (sorted_list),
	.nodes       (nodes)
);

`default_nettype wire

//--- hdl/huffman_tree_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "huff_config.svh"

module huffman_tree_builder (
	input  wire logic                    CLK,
	input  wire logic                    nRST,
	input  wire logic                    start,
	input  wire huff_pkg::weight_array_t weights,
	output huff_pkg::node_table_t        nodes,
	output logic                         done
);

	logic                  load;
	logic                  sort_go;
	logic                  sort_done;
	logic                  merge_go;
	logic                  node_we;
	logic [`HUFF_ID_W-1:0] new_id;
	huff_pkg::entry_list_t sorted_list;
	huff_pkg::entry_list_t list_next;
	huff_pkg::tree_node_t  new_node;

	build_control u_ctrl (
		.CLK       (CLK),
		.nRST      (nRST),
		.start     (start),
		.sort_done (sort_done),
		.node_we   (node_we),
		.load      (load),
		.sort_go   (sort_go),
		.merge_go  (merge_go),
		.new_id    (new_id),
		.done      (done)
	);

	entry_sorter u_sorter (
		.CLK         (CLK),
		.nRST        (nRST),
		.load        (load),
		.weights     (weights),
		.sort_go     (sort_go),
		.list_in     (list_next),
		.sorted_list (sorted_list),
		.sort_done   (sort_done)
	);

	merge_step u_merge (
		.CLK         (CLK),
		.nRST        (nRST),
		.merge_go    (merge_go),
		.new_id      (new_id),
		.sorted_list (sorted_list),
		.list_next   (list_next),
		.new_node    (new_node),
		.node_we     (node_we)
	);

	node_table u_table (
		.CLK      (CLK),
		.nRST     (nRST),
		.load     (load),
		.weights  (weights),
		.new_node (new_node),
		.node_we  (node_we),
		.nodes    (nodes)
	);

endmodule

`default_nettype wire

//--- hdl/build_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "huff_config.svh"

module build_control (
	input  wire logic                   CLK,
	input  wire logic                   nRST,
	input  wire logic                   start,
	input  wire logic                   sort_done,
	input  wire logic                   node_we,
	output logic                        load,
	output logic                        sort_go,
	output logic                        merge_go,
	output logic [`HUFF_ID_W-1:0]       new_id,
	output logic                        done
);

	localparam logic [`HUFF_ID_W-1:0] first_id = `HUFF_ID_W'(`HUFF_LEAVES);
	localparam logic [`HUFF_ID_W-1:0] last_id  = `HUFF_ID_W'(`HUFF_NODES - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_sort,
		st_merge,
		st_finish
	} state_t;

	state_t                state;
	logic [`HUFF_ID_W-1:0] round_id;
	logic                  accept;

	// Start only counts while no build is running
	assign accept = start && (state == st_idle || state == st_finish);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state    <= st_idle;
			round_id <= '0;
		end else begin
			case (state)
				st_idle, st_finish: begin
					if (accept) begin
						state    <= st_sort;
						round_id <= first_id;
					end
				end
				st_sort: begin
					if (sort_done)
						state <= st_merge;
				end
				st_merge: begin
					if (node_we) begin
						if (round_id == last_id) begin
							state <= st_finish;
						end else begin
							state    <= st_sort;
							round_id <= round_id + 1'b1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Load also kicks off the first sort
	assign load     = accept;
	assign merge_go = (state == st_sort) && sort_done;
	assign sort_go  = (state == st_merge) && node_we && (round_id != last_id);
	assign new_id   = round_id;
	assign done     = (state == st_finish);

endmodule

`default_nettype wire

//--- hdl/node_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "huff_config.svh"

module node_table (
	input  wire logic                    CLK,
	input  wire logic                    nRST,
	input  wire logic                    load,
	input  wire huff_pkg::weight_array_t weights,
	input  wire huff_pkg::tree_node_t    new_node,
	input  wire logic                    node_we,
	output huff_pkg::node_table_t        nodes
);

	huff_pkg::node_table_t table_q;
	huff_pkg::node_table_t init_table;

	// Leaves from the inputs, internal slots blank
	always_comb begin
		init_table = '0;
		for (int i = 0; i < `HUFF_LEAVES; i++) begin
			init_table[i].left   = `HUFF_NO_NODE;
			init_table[i].right  = `HUFF_NO_NODE;
			init_table[i].weight = weights[i];
			init_table[i].id     = `HUFF_ID_W'(i);
		end
	end

	////////////////////
	// Table update
	////////////////////

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			table_q <= '0;
		end else if (load) begin
			table_q <= init_table;
		end else if (node_we) begin
			table_q[new_node.id] <= new_node;

			// Link both children back to the new node
			table_q[new_node.left].has_parent  <= 1'b1;
			table_q[new_node.left].parent      <= new_node.id;
			table_q[new_node.right].has_parent <= 1'b1;
			table_q[new_node.right].parent     <= new_node.id;
		end
	end

	assign nodes = table_q;

endmodule

`default_nettype wire

//--- hdl/merge_step.sv
`timescale 1ns/1ps
`default_nettype none

`include "huff_config.svh"

module merge_step (
	input  wire logic                  CLK,
	input  wire logic                  nRST,
	input  wire logic                  merge_go,
	input  wire logic [`HUFF_ID_W-1:0] new_id,
	input  wire huff_pkg::entry_list_t sorted_list,
	output huff_pkg::entry_list_t      list_next,
	output huff_pkg::tree_node_t       new_node,
	output logic                       node_we
);

	huff_pkg::entry_t          first;
	huff_pkg::entry_t          second;
	logic [`HUFF_WEIGHT_W-1:0] sum;

	assign first  = sorted_list[0];
	assign second = sorted_list[1];

	// Wraps modulo 256
	assign sum = first.weight + second.weight;

	always_ff @(posedge CLK) begin
		if (merge_go) begin
			new_node.has_parent <= 1'b0;
			new_node.parent     <= '0;
			new_node.left       <= first.id;
			new_node.right      <= second.id;
			new_node.weight     <= sum;
			new_node.id         <= new_id;

			// Merged node takes slot 0, slot 1 drops out
			list_next           <= sorted_list;
			list_next[0].valid  <= 1'b1;
			list_next[0].weight <= sum;
			list_next[0].id     <= new_id;
			list_next[1].valid  <= 1'b0;
			list_next[1].weight <= '0;
			list_next[1].id     <= `HUFF_NO_NODE;
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST)
			node_we <= 1'b0;
		else
			node_we <= merge_go;
	end

endmodule

`default_nettype wire

//--- hdl/entry_sorter.sv
`timescale 1ns/1ps
`default_nettype none

`include "huff_config.svh"

module entry_sorter (
	input  wire logic                  CLK,
	input  wire logic                  nRST,
	input  wire logic                  load,
	input  wire huff_pkg::weight_array_t weights,
	input  wire logic                  sort_go,
	input  wire huff_pkg::entry_list_t list_in,
	output huff_pkg::entry_list_t      sorted_list,
	output logic                       sort_done
);

	localparam int cnt_w = $clog2(`HUFF_LEAVES);
	localparam logic [cnt_w-1:0] last_pass = cnt_w'(`HUFF_LEAVES - 1);

	huff_pkg::entry_list_t list_q;
	huff_pkg::entry_list_t leaves;
	logic [cnt_w-1:0]      pass_cnt;
	logic                  busy;

	// True when x belongs in front of y
	function automatic logic ahead(input huff_pkg::entry_t x, input huff_pkg::entry_t y);
		if (x.valid != y.valid)
			return x.valid;
		if (!x.valid)
			return 1'b0;
		if (x.weight != y.weight)
			return x.weight < y.weight;
		return x.id < y.id;
	endfunction

	// One compare-exchange pass over even or odd pairs
	function automatic huff_pkg::entry_list_t oe_pass(
		input huff_pkg::entry_list_t l,
		input logic                  odd
	);
		huff_pkg::entry_list_t r;
		r = l;
		for (int i = 0; i < `HUFF_LEAVES - 1; i++) begin
			if ((i % 2) == int'(odd) && ahead(l[i+1], l[i])) begin
				r[i]   = l[i+1];
				r[i+1] = l[i];
			end
		end
		return r;
	endfunction

	always_comb begin
		for (int i = 0; i < `HUFF_LEAVES; i++) begin
			leaves[i].valid  = 1'b1;
			leaves[i].weight = weights[i];
			leaves[i].id     = `HUFF_ID_W'(i);
		end
	end

	////////////////////
	// List datapath
	////////////////////

	// The first pass runs on the capture edge, load starts round one
	always_ff @(posedge CLK) begin
		if (load)
			list_q <= oe_pass(leaves, 1'b0);
		else if (sort_go)
			list_q <= oe_pass(list_in, 1'b0);
		else if (busy)
			list_q <= oe_pass(list_q, pass_cnt[0]);
	end

	////////////////////
	// Pass counter
	////////////////////

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			busy      <= 1'b0;
			pass_cnt  <= '0;
			sort_done <= 1'b0;
		end else begin
			sort_done <= 1'b0;
			if (load || sort_go) begin
				busy     <= 1'b1;
				pass_cnt <= cnt_w'(1);
			end else if (busy) begin
				pass_cnt <= pass_cnt + 1'b1;
				if (pass_cnt == last_pass) begin
					busy      <= 1'b0;
					sort_done <= 1'b1;
				end
			end
		end
	end

	assign sorted_list = list_q;

endmodule

`default_nettype wire

//--- hdl/huff_pkg.sv
`default_nettype none

`include "huff_config.svh"

package huff_pkg;

	////////////////////
	// Working list
	////////////////////

	// One slot of the list being sorted and reduced
	typedef struct packed {
		logic                      valid;
		logic [`HUFF_WEIGHT_W-1:0] weight;
		logic [`HUFF_ID_W-1:0]     id;
	} entry_t;

	// Slot 0 is the front of the list
	typedef entry_t [`HUFF_LEAVES-1:0] entry_list_t;

	////////////////////
	// Tree table
	////////////////////

	typedef struct packed {
		logic                      has_parent;
		logic [`HUFF_ID_W-1:0]     parent;
		logic [`HUFF_ID_W-1:0]     left;
		logic [`HUFF_ID_W-1:0]     right;
		logic [`HUFF_WEIGHT_W-1:0] weight;
		logic [`HUFF_ID_W-1:0]     id;
	} tree_node_t;

	// Indexed by node ID
	typedef tree_node_t [`HUFF_NODES-1:0] node_table_t;

	// Symbol frequencies, index is the leaf ID
	typedef logic [`HUFF_LEAVES-1:0][`HUFF_WEIGHT_W-1:0] weight_array_t;

endpackage

`default_nettype wire

//--- hdl/huff_config.svh
`ifndef HUFF_CONFIG_SVH
`define HUFF_CONFIG_SVH

// Symbol count and derived tree size
`define HUFF_LEAVES 10
`define HUFF_NODES 19

// Field widths
`define HUFF_WEIGHT_W 8
`define HUFF_ID_W 5

// Child field of a leaf
`define HUFF_NO_NODE 5'b11111

`endif
